//--- include/rv_opcodes.svh
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// RV32 base opcode shared by all register-register ALU instructions
`define RV_OPCODE_OP        7'b0110011

// funct7 that selects the M extension (multiply / divide) within OP
`define RV_FUNCT7_MULDIV    7'b0000001

// funct3 codes of the four multiply operations
`define RV_FUNCT3_MUL       3'b000
`define RV_FUNCT3_MULH      3'b001  // signed x signed, high half
`define RV_FUNCT3_MULHSU    3'b010  // signed x unsigned, high half
`define RV_FUNCT3_MULHU     3'b011  // unsigned x unsigned, high half

// funct3 codes 3'b100 .. 3'b111 are the divide and remainder ops,
// which this unit treats as illegal

`endif

//--- sim.f
+incdir+include
verilog/mult_pkg.sv
verilog/mult_decode.sv
verilog/mult_stage.sv
verilog/mult_pipe.sv
verilog/mult_result_queue.sv
verilog/mult_unit.sv
test/mult_unit_tb.sv

//--- test/mult_unit_tb.sv
`timescale 1ns/1ps

`include "rv_opcodes.svh"

module mult_unit_tb;

    localparam int MULT_STAGES = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int FIXED_ROWS  = 14;
    localparam int BURST_ROWS  = MULT_STAGES + QUEUE_DEPTH + 2;  // enough to fill pipe and queue
    localparam int RANDOM_ROWS = 40;
    localparam int NUM_ROWS    = FIXED_ROWS + BURST_ROWS + RANDOM_ROWS;
    localparam longint WATCHDOG_NS = NUM_ROWS * (MULT_STAGES + QUEUE_DEPTH + 20) * 10;

    // one line of stimulus with a cdb_ready pattern walked one bit per cycle
    typedef struct packed {
        logic [6:0]      opcode;
        logic [6:0]      funct7;
        logic [2:0]      funct3;
        mult_pkg::data_t opa;
        mult_pkg::data_t opb;
        logic [7:0]      cdb_pattern;
    } stim_row_t;

    logic                    clock;
    logic                    reset;
    logic                    issue_valid;
    mult_pkg::issue_packet_t issue;
    logic                    issue_ready;
    logic                    result_valid;
    mult_pkg::fu_result_t    result;
    logic                    cdb_ready;

    stim_row_t            stim_table   [NUM_ROWS];
    mult_pkg::fu_result_t expect_table [NUM_ROWS];
    mult_pkg::fu_result_t expected_q   [$];

    int          fill_index = 0;
    int          accepted = 0;
    int          results_seen = 0;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    logic        backpressure_seen = 1'b0;
    logic        was_held = 1'b0;           // bus saw valid without ready last edge
    mult_pkg::fu_result_t held_result;

    mult_unit #(
        .MULT_STAGES (MULT_STAGES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uut (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result),
        .cdb_ready    (cdb_ready)
    );

    always #5 clock = ~clock;

    // reference model extends per the M-extension rules and picks a half of the 64-bit product
    function automatic mult_pkg::fu_result_t expected_result(stim_row_t row, mult_pkg::tag_t tag);
        mult_pkg::fu_result_t pkt;
        longint               a_ext;
        longint               b_ext;
        longint               prod;
        logic                 legal;
        legal = (row.opcode == `RV_OPCODE_OP) && (row.funct7 == `RV_FUNCT7_MULDIV) &&
                (row.funct3 <= `RV_FUNCT3_MULHU);
        if (row.funct3 == `RV_FUNCT3_MULHU) begin
            a_ext = longint'({32'b0, row.opa});
        end else begin
            a_ext = longint'($signed(row.opa));
        end
        if (row.funct3 == `RV_FUNCT3_MUL || row.funct3 == `RV_FUNCT3_MULH) begin
            b_ext = longint'($signed(row.opb));
        end else begin
            b_ext = longint'({32'b0, row.opb});
        end
        prod = a_ext * b_ext;
        pkt.tag     = tag;
        pkt.illegal = !legal;
        if (!legal) begin
            pkt.result = '0;
        end else if (row.funct3 == `RV_FUNCT3_MUL) begin
            pkt.result = prod[31:0];
        end else begin
            pkt.result = prod[63:32];
        end
        return pkt;
    endfunction

    function automatic stim_row_t make_row(logic [6:0] opcode, logic [6:0] funct7,
                                           logic [2:0] funct3, mult_pkg::data_t opa,
                                           mult_pkg::data_t opb, logic [7:0] pattern);
        stim_row_t row;
        row.opcode      = opcode;
        row.funct7      = funct7;
        row.funct3      = funct3;
        row.opa         = opa;
        row.opb         = opb;
        row.cdb_pattern = pattern;
        return row;
    endfunction

    // R-type word with fixed rs1 and rs2 fields and rd taken from the row index
    function automatic mult_pkg::issue_packet_t make_issue(stim_row_t row, int idx);
        mult_pkg::issue_packet_t pkt;
        pkt.inst = {row.funct7, 5'd2, 5'd1, row.funct3, 5'(idx), row.opcode};
        pkt.a    = row.opa;
        pkt.b    = row.opb;
        pkt.tag  = mult_pkg::tag_t'(idx);
        return pkt;
    endfunction

    function automatic mult_pkg::data_t pick_operand();
        mult_pkg::data_t corners [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h7FFF_FFFF};
        if ($urandom_range(3, 0) == 0) begin
            return corners[$urandom_range(3, 0)];
        end
        return $urandom;
    endfunction

    task automatic add_row(stim_row_t row);
        stim_table[fill_index]   = row;
        expect_table[fill_index] = expected_result(row, mult_pkg::tag_t'(fill_index));
        fill_index++;
    endtask

    task automatic build_table();
        stim_row_t row;
        // mul over sign mixes
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MUL, 32'd3, 32'd7, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MUL,
                         32'hFFFF_FFFD, 32'd7, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MUL,
                         32'h8000_0000, 32'hFFFF_FFFF, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MUL,
                         32'hFFFF_FFFF, 32'hFFFF_FFFF, 8'hFF));
        // high halves
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULH,
                         32'h8000_0000, 32'h8000_0000, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULH,
                         32'hFFFF_FFFF, 32'd7, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULHSU,
                         32'h8000_0000, 32'hFFFF_FFFF, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULHSU,
                         32'hFFFF_FFFF, 32'hFFFF_FFFF, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULHU,
                         32'hFFFF_FFFF, 32'hFFFF_FFFF, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULHU,
                         32'h1234_5678, 32'h9ABC_DEF0, 8'hFF));
        // plain add, OP-IMM opcode and div are no multiplies
        add_row(make_row(`RV_OPCODE_OP, 7'b0000000, 3'b000, 32'd5, 32'd9, 8'hFF));
        add_row(make_row(7'b0010011, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULH,
                         32'hDEAD_BEEF, 32'h1234_5678, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, 3'b100, 32'd100, 32'd7, 8'hFF));
        add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, `RV_FUNCT3_MULH,
                         32'h7FFF_FFFF, 32'h7FFF_FFFF, 8'b0101_0101));
        // burst with the bus held low
        for (int i = 0; i < BURST_ROWS; i++) begin
            add_row(make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, 3'(i % 4),
                             pick_operand(), pick_operand(), 8'h00));
        end
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            row = make_row(`RV_OPCODE_OP, `RV_FUNCT7_MULDIV, 3'($urandom_range(3, 0)),
                           pick_operand(), pick_operand(), 8'($urandom));
            if ($urandom_range(7, 0) == 0) begin
                row.funct7 = 7'($urandom);      // mostly illegal now
            end
            add_row(row);
        end
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h expected 0x%h (result %0d)",
                     name, got, exp, results_seen);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // scoreboard on the bus side
    always @(posedge clock) begin
        mult_pkg::fu_result_t front;
        if (!reset) begin
            if (was_held) begin
                assert (result_valid) else begin
                    failure_count++;
                    $display("result_valid dropped while cdb_ready was low");
                end
                check_field("result.tag (held)", 32'(result.tag), 32'(held_result.tag));
                check_field("result.result (held)", result.result, held_result.result);
                check_field("result.illegal (held)", 32'(result.illegal),
                            32'(held_result.illegal));
            end
            if (result_valid && cdb_ready) begin
                if (expected_q.size() == 0) begin
                    failure_count++;
                    $display("bus transfer with no item in flight, tag %h", result.tag);
                end else begin
                    front = expected_q.pop_front();
                    check_field("result.tag", 32'(result.tag), 32'(front.tag));
                    check_field("result.result", result.result, front.result);
                    check_field("result.illegal", 32'(result.illegal), 32'(front.illegal));
                end
                results_seen++;
            end
            was_held    = result_valid && !cdb_ready;
            held_result = result;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        failure_count++;
        $display("timeout after %0d ns with %0d results outstanding",
                 WATCHDOG_NS, expected_q.size());
        finish_run();
    end

    initial begin
        logic row_done;
        logic release_bus;
        int   cycle_count;
        clock       = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        cdb_ready   = 1'b0;
        cycle_count = 0;
        void'($urandom(99));
        build_table();

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_field("result_valid", 32'(result_valid), 32'h0);
        check_field("issue_ready", 32'(issue_ready), 32'h1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_done    = 1'b0;
            release_bus = 1'b0;
            while (!row_done) begin
                @(negedge clock);
                issue_valid = 1'b1;
                issue       = make_issue(stim_table[r], r);
                if (release_bus) begin
                    cdb_ready = 1'b1;
                end else begin
                    cdb_ready = stim_table[r].cdb_pattern[cycle_count % 8];
                end
                cycle_count++;
                // issue_ready only moves on rising edges, so this is the value at the next one
                if (issue_ready) begin
                    expected_q.push_back(expect_table[r]);
                    accepted++;
                    row_done = 1'b1;
                    check_count++;
                    assert (accepted - results_seen <= MULT_STAGES + QUEUE_DEPTH) else begin
                        failure_count++;
                        $display("issue accepted with %0d items already in flight",
                                 accepted - results_seen - 1);
                    end
                end else if (stim_table[r].cdb_pattern == 8'h00 && !release_bus) begin
                    backpressure_seen = 1'b1;   // queue is full so the bus may drain
                    release_bus       = 1'b1;
                end
            end
        end

        @(negedge clock);
        issue_valid = 1'b0;
        cdb_ready   = 1'b1;
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (MULT_STAGES + 2) @(negedge clock);     // nothing extra may follow

        check_count++;
        assert (results_seen == accepted) else begin
            mismatch_count++;
            $display("Mismatch result count: got 0x%h expected 0x%h", results_seen, accepted);
        end
        check_count++;
        assert (backpressure_seen) else begin
            failure_count++;
            $display("issue_ready never fell while the bus was held low");
        end
        finish_run();
    end

endmodule

//--- verilog/mult_decode.sv
`timescale 1ns/1ps

`include "rv_opcodes.svh"

module mult_decode (
    input  mult_pkg::issue_packet_t issue,
    output mult_pkg::wide_t         mcand,
    output mult_pkg::wide_t         mplier,
    output mult_pkg::mult_func_t    func,
    output logic                    illegal
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       funct3_ok;      // one of the four multiply codes
    logic       a_signed;
    logic       b_signed;

    // R-type fields
    assign opcode = issue.inst[6:0];
    assign funct3 = issue.inst[14:12];
    assign funct7 = issue.inst[31:25];

    always_comb begin
        funct3_ok = 1'b1;
        case (funct3)
            `RV_FUNCT3_MUL:    func = mult_pkg::mult;
            `RV_FUNCT3_MULH:   func = mult_pkg::mulh;
            `RV_FUNCT3_MULHSU: func = mult_pkg::mulhsu;
            `RV_FUNCT3_MULHU:  func = mult_pkg::mulhu;
            default: begin
                func      = mult_pkg::mult;  // div and rem codes are flagged below
                funct3_ok = 1'b0;
            end
        endcase
    end

    assign illegal = (opcode != `RV_OPCODE_OP) ||
                     (funct7 != `RV_FUNCT7_MULDIV) ||
                     !funct3_ok;

    // rs1 is unsigned only for mulhu, rs2 is signed only for mul and mulh
    assign a_signed = (func != mult_pkg::mulhu);
    assign b_signed = (func == mult_pkg::mult) || (func == mult_pkg::mulh);

    assign mcand  = {{32{a_signed & issue.a[31]}}, issue.a};
    assign mplier = {{32{b_signed & issue.b[31]}}, issue.b};

endmodule

//--- verilog/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe #(
    parameter int MULT_STAGES = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  mult_pkg::wide_t        mcand,
    input  mult_pkg::wide_t        mplier,
    input  mult_pkg::stage_ctrl_t  ctrl_in,
    output logic                   push,
    output mult_pkg::fu_result_t   push_data
);

    // index i is the input side of stage i
    mult_pkg::wide_t       sums    [MULT_STAGES];
    mult_pkg::wide_t       mpliers [MULT_STAGES];
    mult_pkg::wide_t       mcands  [MULT_STAGES];
    mult_pkg::stage_ctrl_t ctrls   [MULT_STAGES];

    mult_pkg::wide_t       product;
    mult_pkg::stage_ctrl_t ctrl_last;

    assign sums[0]    = '0;    // accumulation starts from zero
    assign mpliers[0] = mplier;
    assign mcands[0]  = mcand;
    assign ctrls[0]   = ctrl_in;

    for (genvar i = 0; i < MULT_STAGES - 1; i++) begin : gen_stage
        mult_stage #(
            .MULT_STAGES (MULT_STAGES)
        ) stage (
            .clock       (clock),
            .reset       (reset),
            .stall       (stall),
            .prev_sum    (sums[i]),
            .mplier      (mpliers[i]),
            .mcand       (mcands[i]),
            .ctrl_in     (ctrls[i]),
            .product_sum (sums[i+1]),
            .next_mplier (mpliers[i+1]),
            .next_mcand  (mcands[i+1]),
            .ctrl_out    (ctrls[i+1])
        );
    end

    // the shifted operands of the last stage go nowhere
    mult_stage #(
        .MULT_STAGES (MULT_STAGES)
    ) last_stage (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .prev_sum    (sums[MULT_STAGES-1]),
        .mplier      (mpliers[MULT_STAGES-1]),
        .mcand       (mcands[MULT_STAGES-1]),
        .ctrl_in     (ctrls[MULT_STAGES-1]),
        .product_sum (product),
        .next_mplier (),
        .next_mcand  (),
        .ctrl_out    (ctrl_last)
    );

    assign push = ctrl_last.busy && !stall;

    always_comb begin
        push_data.tag     = ctrl_last.tag;
        push_data.illegal = ctrl_last.illegal;
        if (ctrl_last.illegal) begin
            push_data.result = '0;
        end else if (ctrl_last.func == mult_pkg::mult) begin
            push_data.result = product[31:0];
        end else begin
            push_data.result = product[63:32];  // mulh, mulhsu, mulhu
        end
    end

endmodule

//--- verilog/mult_pkg.sv
package mult_pkg;

    // architectural word
    typedef logic [31:0] data_t;

    // extended operand, or the full product
    typedef logic [63:0] wide_t;

    // physical destination register tag
    typedef logic [5:0] tag_t;

    // values match the funct3 field of the instruction word
    typedef enum logic [2:0] {
        mult   = 3'b000,
        mulh   = 3'b001,
        mulhsu = 3'b010,
        mulhu  = 3'b011
    } mult_func_t;

    // packet from the reservation station
    typedef struct packed {
        logic [31:0] inst;      // raw instruction word, R-type layout
        data_t       a;         // rs1 value
        data_t       b;         // rs2 value
        tag_t        tag;
    } issue_packet_t;

    // travels down the multiply pipe alongside the partial sums
    typedef struct packed {
        logic       busy;       // stage holds a live item
        mult_func_t func;
        tag_t       tag;
        logic       illegal;
    } stage_ctrl_t;

    // finished result as it goes out on the common data bus
    typedef struct packed {
        tag_t  tag;
        data_t result;
        logic  illegal;         // word was no M-extension multiply and the result is zero
    } fu_result_t;

    // widths the bus side and the pipe rely on
    // issue_packet_t 102 bits
    // stage_ctrl_t    11 bits
    // fu_result_t     39 bits

endpackage

//--- verilog/mult_result_queue.sv
`timescale 1ns/1ps

module mult_result_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push,
    input  mult_pkg::fu_result_t  push_data,
    output logic                  full,
    output logic                  result_valid,
    output mult_pkg::fu_result_t  result,
    input  logic                  cdb_ready
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mult_pkg::fu_result_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full         = (count == CNT_W'(QUEUE_DEPTH));
    assign result_valid = (count != '0);
    assign result       = mem[rd_ptr];  // head entry stays stable until popped

    assign do_push = push && !full;
    assign do_pop  = result_valid && cdb_ready;

    // payload storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or push and pop together
            endcase
        end
    end

endmodule

//--- verilog/mult_stage.sv
`timescale 1ns/1ps

module mult_stage #(
    parameter int MULT_STAGES = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  mult_pkg::wide_t        prev_sum,
    input  mult_pkg::wide_t        mplier,
    input  mult_pkg::wide_t        mcand,
    input  mult_pkg::stage_ctrl_t  ctrl_in,
    output mult_pkg::wide_t        product_sum,
    output mult_pkg::wide_t        next_mplier,
    output mult_pkg::wide_t        next_mcand,
    output mult_pkg::stage_ctrl_t  ctrl_out
);

    // multiplier bits consumed per stage
    localparam int SHIFT = 64 / MULT_STAGES;

    mult_pkg::wide_t partial_product;

    // only the low 64 bits of the product are ever needed
    assign partial_product = mplier[SHIFT-1:0] * mcand;

    always_ff @(posedge clock) begin
        if (!stall) begin
            product_sum <= prev_sum + partial_product;
            next_mplier <= mplier >> SHIFT;     // next slice moves to the bottom
            next_mcand  <= mcand << SHIFT;      // weight of the next slice
            ctrl_out    <= ctrl_in;
        end
        if (reset) begin
            ctrl_out.busy <= 1'b0;
        end
    end

endmodule

//--- verilog/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
    parameter int MULT_STAGES = 4,  // 2, 4 or 8
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  mult_pkg::issue_packet_t issue,
    output logic                    issue_ready,
    output logic                    result_valid,
    output mult_pkg::fu_result_t    result,
    input  logic                    cdb_ready
);

    mult_pkg::wide_t       mcand;
    mult_pkg::wide_t       mplier;
    mult_pkg::mult_func_t  func;
    logic                  illegal;
    mult_pkg::stage_ctrl_t ctrl_in;
    logic                  full;
    logic                  push;
    mult_pkg::fu_result_t  push_data;

    // a full queue freezes the pipe, so nothing new may enter
    assign issue_ready = !full;

    assign ctrl_in.busy    = issue_valid && issue_ready;
    assign ctrl_in.func    = func;
    assign ctrl_in.tag     = issue.tag;
    assign ctrl_in.illegal = illegal;

    mult_decode decode (
        .issue   (issue),
        .mcand   (mcand),
        .mplier  (mplier),
        .func    (func),
        .illegal (illegal)
    );

    mult_pipe #(
        .MULT_STAGES (MULT_STAGES)
    ) pipe (
        .clock     (clock),
        .reset     (reset),
        .stall     (full),
        .mcand     (mcand),
        .mplier    (mplier),
        .ctrl_in   (ctrl_in),
        .push      (push),
        .push_data (push_data)
    );

    mult_result_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue (
        .clock        (clock),
        .reset        (reset),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .result_valid (result_valid),
        .result       (result),
        .cdb_ready    (cdb_ready)
    );

endmodule
